//--- hdl/bastim_reg_pkg.sv
//==============================
// register map of the basic timer
// bus offsets, control field positions,
// control reset value and per-channel control struct
//==============================

`default_nettype none

package bastim_reg_pkg;

	//==============================
	// global registers
	//==============================
	localparam logic [31:0] ADDR_CTRL      = 32'h0000_0000;
	localparam logic [31:0] ADDR_INT       = 32'h0000_0004;
	localparam logic [31:0] ADDR_UPDATE    = 32'h0000_0008;

	// channel blocks start here, one block per channel
	localparam logic [31:0] ADDR_CH_BASE   = 32'h0000_0010;
	localparam logic [31:0] ADDR_CH_STRIDE = 32'h0000_0010;

	// offsets inside a channel block
	localparam logic [31:0] OFS_PSC        = 32'h0000_0000;
	localparam logic [31:0] OFS_ARR        = 32'h0000_0004;
	localparam logic [31:0] OFS_START      = 32'h0000_0008;
	localparam logic [31:0] OFS_CNT        = 32'h0000_000c;

	// CTRL field positions, eight bits per field
	localparam int CTRL_EN_LSB  = 0;
	localparam int CTRL_AR_LSB  = 8;
	localparam int CTRL_IEN_LSB = 16;

	// all channels stopped, no interrupts
	localparam logic [31:0] CTRL_RST = 32'h0000_0000;

	// per-channel run control
	typedef struct packed {
		logic tim_enable;
		logic auto_reload;
	} ch_ctrl_t;

endpackage

`default_nettype wire

//--- hdl/bastim_tim_pkg.sv
//==============================
// timing definitions of a channel
// counter width, configuration struct
// and its reset value
//==============================

`default_nettype none

package bastim_tim_pkg;

	// prescaler and counter share one width
	localparam int CNT_W = 16;

	// one channel's timing configuration
	typedef struct packed {
		logic [CNT_W-1:0] psc;
		logic [CNT_W-1:0] arr;
		logic [CNT_W-1:0] startcnt;
	} tim_cfg_t;

	localparam tim_cfg_t TIM_CFG_RST = '{psc: 16'h000a, arr: 16'h0028, startcnt: 16'h0000};

endpackage

`default_nettype wire

//--- hdl/bastim_apb_cfg.sv
//==============================
// APB register file of the timer
// address decode, CTRL and shadow registers,
// update and clear pulses, read mux
//==============================

`timescale 1ns/1ns
`default_nettype none

module bastim_apb_cfg
	import bastim_reg_pkg::*, bastim_tim_pkg::*;
#(
	parameter int NUM_CH = 4
)
(
	input  logic                             reg_clk,
	input  logic                             reg_rstn,
	input  logic [31:0]                      paddr,
	input  logic                             pwrite,
	input  logic                             psel,
	input  logic                             penable,
	input  logic [31:0]                      pwdata,
	output logic [31:0]                      prdata,
	output ch_ctrl_t [NUM_CH-1:0]            ch_ctrl,
	output logic [NUM_CH-1:0]                int_en,
	output logic [NUM_CH-1:0]                int_clr,
	output logic [NUM_CH-1:0]                update,
	output tim_cfg_t [NUM_CH-1:0]            shadow_cfg,
	input  logic [NUM_CH-1:0]                int_sta,
	input  logic [NUM_CH-1:0][CNT_W-1:0]     cnt
);

	logic              wr_en;
	logic              sel_ctrl;
	logic              sel_int;
	logic              sel_update;
	logic [NUM_CH-1:0] sel_psc;
	logic [NUM_CH-1:0] sel_arr;
	logic [NUM_CH-1:0] sel_start;
	logic [NUM_CH-1:0] sel_cnt;
	logic [31:0]       ctrl_rd;

	// write happens in the access phase
	assign wr_en = psel & penable & pwrite;

	//==============================
	// address decode
	//==============================
	assign sel_ctrl   = (paddr == ADDR_CTRL);
	assign sel_int    = (paddr == ADDR_INT);
	assign sel_update = (paddr == ADDR_UPDATE);

	for (genvar gi = 0; gi < NUM_CH; gi++)
	begin : g_dec
		localparam logic [31:0] CH_BASE = ADDR_CH_BASE + gi * ADDR_CH_STRIDE;

		assign sel_psc[gi]   = (paddr == CH_BASE + OFS_PSC);
		assign sel_arr[gi]   = (paddr == CH_BASE + OFS_ARR);
		assign sel_start[gi] = (paddr == CH_BASE + OFS_START);
		assign sel_cnt[gi]   = (paddr == CH_BASE + OFS_CNT);
	end

	//==============================
	// CTRL register
	//==============================
	always_ff @(posedge reg_clk or negedge reg_rstn)
	begin
		if (!reg_rstn)
		begin
			for (int i = 0; i < NUM_CH; i++)
			begin
				ch_ctrl[i].tim_enable  <= CTRL_RST[CTRL_EN_LSB + i];
				ch_ctrl[i].auto_reload <= CTRL_RST[CTRL_AR_LSB + i];
				int_en[i]              <= CTRL_RST[CTRL_IEN_LSB + i];
			end
		end
		else if (wr_en && sel_ctrl)
		begin
			for (int i = 0; i < NUM_CH; i++)
			begin
				ch_ctrl[i].tim_enable  <= pwdata[CTRL_EN_LSB + i];
				ch_ctrl[i].auto_reload <= pwdata[CTRL_AR_LSB + i];
				int_en[i]              <= pwdata[CTRL_IEN_LSB + i];
			end
		end
	end

	// one-cycle pulses, low unless the matching write lands
	always_ff @(posedge reg_clk or negedge reg_rstn)
	begin
		if (!reg_rstn)
		begin
			update  <= '0;
			int_clr <= '0;
		end
		else
		begin
			update  <= (wr_en && sel_update) ? pwdata[NUM_CH-1:0] : '0;
			int_clr <= (wr_en && sel_int) ? pwdata[NUM_CH-1:0] : '0;
		end
	end

	//==============================
	// shadow configuration
	//==============================
	always_ff @(posedge reg_clk or negedge reg_rstn)
	begin
		if (!reg_rstn)
		begin
			shadow_cfg <= {NUM_CH{TIM_CFG_RST}};
		end
		else if (wr_en)
		begin
			for (int i = 0; i < NUM_CH; i++)
			begin
				if (sel_psc[i])
					shadow_cfg[i].psc <= pwdata[CNT_W-1:0];
				if (sel_arr[i])
					shadow_cfg[i].arr <= pwdata[CNT_W-1:0];
				if (sel_start[i])
					shadow_cfg[i].startcnt <= pwdata[CNT_W-1:0];
			end
		end
	end

	//==============================
	// read mux
	//==============================
	always_comb
	begin
		ctrl_rd = '0;
		for (int i = 0; i < NUM_CH; i++)
		begin
			ctrl_rd[CTRL_EN_LSB + i]  = ch_ctrl[i].tim_enable;
			ctrl_rd[CTRL_AR_LSB + i]  = ch_ctrl[i].auto_reload;
			ctrl_rd[CTRL_IEN_LSB + i] = int_en[i];
		end
	end

	// UPDATE and unmapped addresses fall through as zero
	always_comb
	begin
		prdata = '0;
		if (psel)
		begin
			if (sel_ctrl)
				prdata = ctrl_rd;
			if (sel_int)
				prdata[NUM_CH-1:0] = int_sta;
			for (int i = 0; i < NUM_CH; i++)
			begin
				if (sel_psc[i])
					prdata = 32'(shadow_cfg[i].psc);
				if (sel_arr[i])
					prdata = 32'(shadow_cfg[i].arr);
				if (sel_start[i])
					prdata = 32'(shadow_cfg[i].startcnt);
				if (sel_cnt[i])
					prdata = 32'(cnt[i]);
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/bastim_regs_wrap.sv
//==============================
// active configuration registers
// shadow copied in per channel on update
//==============================

`timescale 1ns/1ns
`default_nettype none

module bastim_regs_wrap
	import bastim_tim_pkg::*;
#(
	parameter int NUM_CH = 4
)
(
	input  logic                  reg_clk,
	input  logic                  reg_rstn,
	input  logic [NUM_CH-1:0]     update,
	input  tim_cfg_t [NUM_CH-1:0] shadow_cfg,
	output tim_cfg_t [NUM_CH-1:0] active_cfg
);

	//==============================
	// per-channel transfer
	//==============================
	// a running counter only ever sees a complete set,
	// software finishes psc/arr/start before it strobes update
	for (genvar gi = 0; gi < NUM_CH; gi++)
	begin : g_act
		always_ff @(posedge reg_clk or negedge reg_rstn)
		begin
			if (!reg_rstn)
			begin
				active_cfg[gi] <= TIM_CFG_RST;
			end
			else if (update[gi])
			begin
				// whole struct moves in one edge
				active_cfg[gi] <= shadow_cfg[gi];
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/bastim_channel.sv
//==============================
// one timer channel
// prescaler, up counter, reload or stop,
// registered overflow pulse
//==============================

`timescale 1ns/1ns
`default_nettype none

module bastim_channel
	import bastim_reg_pkg::*, bastim_tim_pkg::*;
(
	input  logic             reg_clk,
	input  logic             reg_rstn,
	input  ch_ctrl_t         ctrl,
	input  tim_cfg_t         cfg,
	output logic [CNT_W-1:0] cnt,
	output logic             ovf
);

	logic [CNT_W-1:0] psc_cnt;
	logic             tick;
	logic             at_arr;
	logic             done;

	// count tick every psc+1 cycles
	assign tick   = ctrl.tim_enable && !done && (psc_cnt == cfg.psc);
	assign at_arr = (cnt == cfg.arr);

	//==============================
	// prescaler
	//==============================
	always_ff @(posedge reg_clk or negedge reg_rstn)
	begin
		if (!reg_rstn)
			psc_cnt <= '0;
		else if (!ctrl.tim_enable || tick)
			psc_cnt <= '0;
		else if (!done)
			psc_cnt <= psc_cnt + 1'b1;
	end

	//==============================
	// counter and overflow
	//==============================
	always_ff @(posedge reg_clk or negedge reg_rstn)
	begin
		if (!reg_rstn)
		begin
			cnt  <= TIM_CFG_RST.startcnt;
			ovf  <= 1'b0;
			done <= 1'b0;
		end
		else if (!ctrl.tim_enable)
		begin
			// idle, parked at the start value
			cnt  <= cfg.startcnt;
			ovf  <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			ovf <= tick && at_arr;
			if (tick)
			begin
				if (!at_arr)
					cnt <= cnt + 1'b1;
				else if (ctrl.auto_reload)
					cnt <= cfg.startcnt;
				else
					// one-shot, hold at arr until disabled
					done <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/bastim_int_ctrl.sv
//==============================
// interrupt control
// sticky status, W1C clear, masked irq
//==============================

`timescale 1ns/1ns
`default_nettype none

module bastim_int_ctrl
#(
	parameter int NUM_CH = 4
)
(
	input  logic              reg_clk,
	input  logic              reg_rstn,
	input  logic [NUM_CH-1:0] ovf,
	input  logic [NUM_CH-1:0] int_en,
	input  logic [NUM_CH-1:0] int_clr,
	output logic [NUM_CH-1:0] int_sta,
	output logic              irq
);

	// status bits, a new overflow beats a clear in the same cycle
	always_ff @(posedge reg_clk or negedge reg_rstn)
	begin
		if (!reg_rstn)
			int_sta <= '0;
		else
			int_sta <= ovf | (int_sta & ~int_clr);
	end

	// irq line, one cycle behind status
	always_ff @(posedge reg_clk or negedge reg_rstn)
	begin
		if (!reg_rstn)
			irq <= 1'b0;
		else
			irq <= |(int_sta & int_en);
	end

endmodule

`default_nettype wire

//--- hdl/bastim_top.sv
//==============================
// basic timer top level
// register file, config wrapper,
// timer channels, interrupt control
//==============================

`timescale 1ns/1ns
`default_nettype none

module bastim_top
	import bastim_reg_pkg::*, bastim_tim_pkg::*;
#(
	parameter int NUM_CH = 4
)
(
	input  logic        reg_clk,
	input  logic        reg_rstn,
	input  logic [31:0] paddr,
	input  logic        pwrite,
	input  logic        psel,
	input  logic        penable,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        irq
);

	ch_ctrl_t [NUM_CH-1:0]        ch_ctrl;
	tim_cfg_t [NUM_CH-1:0]        shadow_cfg;
	tim_cfg_t [NUM_CH-1:0]        active_cfg;
	logic [NUM_CH-1:0]            int_en;
	logic [NUM_CH-1:0]            int_clr;
	logic [NUM_CH-1:0]            int_sta;
	logic [NUM_CH-1:0]            update;
	logic [NUM_CH-1:0]            ovf;
	logic [NUM_CH-1:0][CNT_W-1:0] cnt;

	//==============================
	// register file and wrapper
	//==============================
	bastim_apb_cfg #(
		.NUM_CH     (NUM_CH)
	) u_apb_cfg (
		.reg_clk    (reg_clk),
		.reg_rstn   (reg_rstn),
		.paddr      (paddr),
		.pwrite     (pwrite),
		.psel       (psel),
		.penable    (penable),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.ch_ctrl    (ch_ctrl),
		.int_en     (int_en),
		.int_clr    (int_clr),
		.update     (update),
		.shadow_cfg (shadow_cfg),
		.int_sta    (int_sta),
		.cnt        (cnt)
	);

	bastim_regs_wrap #(
		.NUM_CH     (NUM_CH)
	) u_regs_wrap (
		.reg_clk    (reg_clk),
		.reg_rstn   (reg_rstn),
		.update     (update),
		.shadow_cfg (shadow_cfg),
		.active_cfg (active_cfg)
	);

	//==============================
	// channels and interrupts
	//==============================
	for (genvar gi = 0; gi < NUM_CH; gi++)
	begin : g_ch
		bastim_channel u_channel (
			.reg_clk  (reg_clk),
			.reg_rstn (reg_rstn),
			.ctrl     (ch_ctrl[gi]),
			.cfg      (active_cfg[gi]),
			.cnt      (cnt[gi]),
			.ovf      (ovf[gi])
		);
	end

	bastim_int_ctrl #(
		.NUM_CH   (NUM_CH)
	) u_int_ctrl (
		.reg_clk  (reg_clk),
		.reg_rstn (reg_rstn),
		.ovf      (ovf),
		.int_en   (int_en),
		.int_clr  (int_clr),
		.int_sta  (int_sta),
		.irq      (irq)
	);

endmodule

`default_nettype wire

//--- testbench/bastim_tb.sv
//==============================
// testbench of the basic timer
// clock, reset, APB tasks, LCG,
// configuration model and checks
//==============================

`timescale 1ns/1ns
`default_nettype none

module bastim_tb
	import bastim_reg_pkg::*;
();

	localparam int NUM_CH   = 4;
	localparam int WAIT_MAX = 5000;
	localparam int TOL      = 3;
	// status and irq each add one edge after ovf
	localparam int IRQ_LAT  = 2;

	logic        reg_clk;
	logic        reg_rstn;
	logic [31:0] paddr;
	logic        pwrite;
	logic        psel;
	logic        penable;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        irq;
	logic [31:0] rng_state = 32'h1d90;
	int          cyc = 0;
	int          err_cnt = 0;
	int          tmo_cnt = 0;
	// model of shadow and active configuration
	logic [31:0] sh_psc [NUM_CH];
	logic [31:0] sh_arr [NUM_CH];
	logic [31:0] sh_start [NUM_CH];
	logic [31:0] act_psc [NUM_CH];
	logic [31:0] act_arr [NUM_CH];
	logic [31:0] act_start [NUM_CH];

	bastim_top #(.NUM_CH(NUM_CH)) dut0 (
		.reg_clk(reg_clk), .reg_rstn(reg_rstn), .paddr(paddr), .pwrite(pwrite),
		.psel(psel), .penable(penable), .pwdata(pwdata), .prdata(prdata), .irq(irq)
	);

	initial
	begin
		reg_clk = 1'b0;
		forever #20 reg_clk = ~reg_clk;
	end

	// cycle stamp read at falling edges only
	always @(posedge reg_clk)
		cyc <= cyc + 1;

	//==============================
	// helpers
	//==============================
	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	function automatic logic [31:0] ch_addr(input int ch, input logic [31:0] ofs);
		return ADDR_CH_BASE + ADDR_CH_STRIDE * ch + ofs;
	endfunction

	function automatic logic [31:0] ctrl_word(input int ch, input logic en, input logic ar,
		input logic ien);
		logic [31:0] w;
		w = '0;
		w[ch] = en;
		w[8 + ch] = ar;
		w[16 + ch] = ien;
		return w;
	endfunction

	// (arr - start + 1) * (psc + 1)
	function automatic int ovf_period(input int ch);
		return int'((act_arr[ch] - act_start[ch] + 32'd1) * (act_psc[ch] + 32'd1));
	endfunction

	// cycle counts within the tolerance count as exact
	function automatic int snap_to_expected(input int got, input int exp);
		return (got >= exp - TOL && got <= exp + TOL) ? exp : got;
	endfunction

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp)
		begin
			$display("error at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	// all bus tasks return just after a falling edge
	task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
		@(posedge reg_clk);
		psel <= 1'b1;
		pwrite <= 1'b1;
		paddr <= addr;
		pwdata <= data;
		@(posedge reg_clk);
		penable <= 1'b1;
		@(posedge reg_clk);
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
		@(negedge reg_clk);
	endtask

	task automatic apb_read(input logic [31:0] addr, output logic [31:0] data);
		@(posedge reg_clk);
		psel <= 1'b1;
		pwrite <= 1'b0;
		paddr <= addr;
		@(posedge reg_clk);
		penable <= 1'b1;
		@(negedge reg_clk);
		data = prdata;
		@(posedge reg_clk);
		psel <= 1'b0;
		penable <= 1'b0;
		@(negedge reg_clk);
	endtask

	task automatic wait_irq(input logic level, input string what, output int t);
		int n;
		n = 0;
		while (irq !== level && n < WAIT_MAX)
		begin
			@(negedge reg_clk);
			n++;
		end
		if (irq !== level)
		begin
			$display("timeout: irq never went to %0b while %s", level, what);
			tmo_cnt++;
		end
		t = cyc;
	endtask

	task automatic randomize_shadow(input int ch, input logic [31:0] min_psc,
		input logic [31:0] min_span);
		sh_psc[ch] = min_psc + (next_rand() & 32'h3);
		sh_start[ch] = next_rand() & 32'h7;
		sh_arr[ch] = sh_start[ch] + min_span + (next_rand() & 32'hf);
		apb_write(ch_addr(ch, OFS_PSC), sh_psc[ch]);
		apb_write(ch_addr(ch, OFS_ARR), sh_arr[ch]);
		apb_write(ch_addr(ch, OFS_START), sh_start[ch]);
	endtask

	// cycles from enabling one channel until irq rises
	task automatic time_first_irq(input int ch, input logic ar, output int dt);
		int t0;
		int t1;
		apb_write(ADDR_CTRL, ctrl_word(ch, 1'b1, ar, 1'b1));
		t0 = cyc;
		wait_irq(1'b1, "waiting for first overflow", t1);
		dt = t1 - t0;
	endtask

	task automatic stop_channel(input int ch);
		int t;
		apb_write(ADDR_CTRL, 32'h0);
		apb_write(ADDR_INT, 32'h1 << ch);
		wait_irq(1'b0, "stopping a channel", t);
	endtask

	//==============================
	// stimulus
	//==============================
	initial
	begin
		logic [31:0] rd;
		logic [31:0] mask;
		logic        seen;
		int          dt;
		int          exp;
		int          ch;
		int          n;
		int          t0;
		int          t1;
		reg_rstn = 1'b0;
		paddr = '0;
		pwrite = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwdata = '0;
		repeat (8) @(posedge reg_clk);
		reg_rstn <= 1'b1;
		@(negedge reg_clk);

		// reset values
		for (int i = 0; i < NUM_CH; i++)
		begin
			sh_psc[i] = 32'h000a;
			sh_arr[i] = 32'h0028;
			sh_start[i] = 32'h0;
			act_psc[i] = sh_psc[i];
			act_arr[i] = sh_arr[i];
			act_start[i] = sh_start[i];
			apb_read(ch_addr(i, OFS_PSC), rd);
			check_eq(rd, sh_psc[i], "PSC after reset");
			apb_read(ch_addr(i, OFS_ARR), rd);
			check_eq(rd, sh_arr[i], "ARR after reset");
			apb_read(ch_addr(i, OFS_START), rd);
			check_eq(rd, sh_start[i], "START after reset");
		end
		apb_read(ADDR_CTRL, rd);
		check_eq(rd, 32'h0, "CTRL after reset");

		// new shadow values must not reach the counters yet
		for (int i = 0; i < NUM_CH; i++)
		begin
			randomize_shadow(i, 32'h0, 32'h0);
			apb_read(ch_addr(i, OFS_PSC), rd);
			check_eq(rd, sh_psc[i], "PSC shadow read-back");
			apb_read(ch_addr(i, OFS_ARR), rd);
			check_eq(rd, sh_arr[i], "ARR shadow read-back");
			apb_read(ch_addr(i, OFS_START), rd);
			check_eq(rd, sh_start[i], "START shadow read-back");
		end
		for (int i = 0; i < NUM_CH; i++)
		begin
			exp = ovf_period(i) + IRQ_LAT;
			time_first_irq(i, 1'b0, dt);
			check_eq(snap_to_expected(dt, exp), exp, "period before update");
			stop_channel(i);
		end

		// update a random subset
		mask = next_rand() & 32'hf;
		if (mask == 32'h0)
			mask = 32'h1;
		apb_write(ADDR_UPDATE, mask);
		for (int i = 0; i < NUM_CH; i++)
		begin
			if (mask[i])
			begin
				act_psc[i] = sh_psc[i];
				act_arr[i] = sh_arr[i];
				act_start[i] = sh_start[i];
			end
		end
		apb_read(ADDR_UPDATE, rd);
		check_eq(rd, 32'h0, "UPDATE read-back");
		for (int i = 0; i < NUM_CH; i++)
		begin
			exp = ovf_period(i) + IRQ_LAT;
			time_first_irq(i, 1'b0, dt);
			check_eq(snap_to_expected(dt, exp), exp, "period after update");
			stop_channel(i);
		end

		//==============================
		// auto-reload then one-shot
		//==============================
		ch = 2;
		randomize_shadow(ch, 32'h1, 32'h8);
		apb_write(ADDR_UPDATE, 32'h1 << ch);
		act_psc[ch] = sh_psc[ch];
		act_arr[ch] = sh_arr[ch];
		act_start[ch] = sh_start[ch];
		exp = ovf_period(ch) + IRQ_LAT;
		time_first_irq(ch, 1'b1, dt);
		check_eq(snap_to_expected(dt, exp), exp, "auto-reload first period");
		t0 = cyc;
		repeat (2)
		begin
			apb_write(ADDR_INT, 32'h1 << ch);
			wait_irq(1'b0, "clearing auto-reload status", t1);
			wait_irq(1'b1, "waiting for reload overflow", t1);
			check_eq(snap_to_expected(t1 - t0, ovf_period(ch)), ovf_period(ch),
				"auto-reload period");
			t0 = t1;
		end
		stop_channel(ch);

		time_first_irq(ch, 1'b0, dt);
		check_eq(snap_to_expected(dt, exp), exp, "one-shot period");
		apb_write(ADDR_INT, 32'h1 << ch);
		wait_irq(1'b0, "clearing one-shot status", t1);
		seen = 1'b0;
		repeat (3 * ovf_period(ch))
		begin
			@(negedge reg_clk);
			seen |= irq;
		end
		check_eq(32'(seen), 32'h0, "one-shot irq repeated");
		apb_read(ch_addr(ch, OFS_CNT), rd);
		check_eq(rd, act_arr[ch], "one-shot CNT");
		repeat (10) @(negedge reg_clk);
		apb_read(ch_addr(ch, OFS_CNT), rd);
		check_eq(rd, act_arr[ch], "one-shot CNT held");
		stop_channel(ch);

		// masked status then enable and clear
		ch = 3;
		apb_write(ADDR_CTRL, ctrl_word(ch, 1'b1, 1'b0, 1'b0));
		seen = 1'b0;
		n = 0;
		rd = '0;
		while (rd[ch] == 1'b0 && n < WAIT_MAX)
		begin
			apb_read(ADDR_INT, rd);
			seen |= irq;
			n++;
		end
		if (rd[ch] == 1'b0)
		begin
			$display("timeout: status bit of channel %0d never set", ch);
			tmo_cnt++;
		end
		check_eq(32'(seen | irq), 32'h0, "irq while masked");
		apb_write(ADDR_CTRL, ctrl_word(ch, 1'b1, 1'b0, 1'b1));
		wait_irq(1'b1, "unmasking the interrupt", t1);
		apb_write(ADDR_INT, 32'h1 << ch);
		apb_read(ADDR_INT, rd);
		check_eq(rd, 32'h0, "INT after clear");
		wait_irq(1'b0, "clearing a stopped channel", t1);
		stop_channel(ch);

		$display("checks done, %0d errors, %0d timeouts", err_cnt, tmo_cnt);
		if (err_cnt == 0 && tmo_cnt == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
hdl/bastim_reg_pkg.sv
hdl/bastim_tim_pkg.sv
hdl/bastim_apb_cfg.sv
hdl/bastim_regs_wrap.sv
hdl/bastim_channel.sv
hdl/bastim_int_ctrl.sv
hdl/bastim_top.sv
testbench/bastim_tb.sv

//--- Makefile
SIM_LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f build.f --top-module bastim_top
	verilator --lint-only --timing -f build.f --top-module bastim_tb

sim:
	verilator --binary --timing -f build.f --top-module bastim_tb -o bastim_sim
	./obj_dir/bastim_sim | tee $(SIM_LOG)
	grep -q "Test completed successfully" $(SIM_LOG)

clean:
	rm -rf obj_dir $(SIM_LOG)
